// File: rtl/lsab_pkg.sv
package lsab_pkg;

  // selector width fixes the queue count
  localparam int NUM_QUEUES = 4;
  localparam int RAM_ADDR_W = 8;
  localparam int DATA_W     = 32;
  localparam int ANCILL_W   = 3;

  typedef enum logic [1:0] {
    QUEUE_0 = 2'd0,
    QUEUE_1 = 2'd1,
    QUEUE_2 = 2'd2,
    QUEUE_3 = 2'd3
  } lsab_queue_e;

  // one incoming word from the producer
  typedef struct packed {
    logic                marker; // tag word for a consumer stop
    logic [ANCILL_W-1:0] ancill;
    logic [DATA_W-1:0]   data;
  } lsab_push_t;

  // per-queue outputs
  typedef struct packed {
    logic                empty;
    logic                stop;
    logic                int_out;
    logic [ANCILL_W-1:0] ancill;
  } lsab_status_t;

endpackage

// File: rtl/lsab_ram.sv
`timescale 1ns/1ns

module lsab_ram #(
  parameter int ADDR_W = lsab_pkg::RAM_ADDR_W,
  parameter int DATA_W = lsab_pkg::DATA_W
) (
  input  logic              CLK,
  input  logic              we,
  input  logic [ADDR_W-1:0] waddr,
  input  logic [DATA_W-1:0] wdata,
  input  logic              re,
  input  logic [ADDR_W-1:0] raddr,
  output logic [DATA_W-1:0] rdata
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];

  always_ff @(posedge CLK) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // read data only moves on enabled edges
  always_ff @(posedge CLK) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

// File: rtl/lsab_queue_ctrl.sv
`timescale 1ns/1ns

module lsab_queue_ctrl #(
  parameter int                  PTR_W           = 6,
  parameter int                  MARK_SLOTS_LOG2 = 2,
  parameter lsab_pkg::lsab_queue_e QUEUE_ID      = lsab_pkg::QUEUE_0
) (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   write,
  input  lsab_pkg::lsab_queue_e  write_queue,
  input  lsab_pkg::lsab_push_t   push,
  input  logic                   read,
  input  lsab_pkg::lsab_queue_e  read_queue,
  input  logic                   careof_int,
  output logic                   do_write,
  output logic                   do_read,
  output logic [PTR_W-1:0]       wptr,
  output logic [PTR_W-1:0]       rptr,
  output lsab_pkg::lsab_status_t status
);

  localparam int MARK_SLOTS = 1 << MARK_SLOTS_LOG2;

  logic [PTR_W-1:0] len;
  logic [PTR_W-1:0] len_next;
  logic             full;
  logic             full_next;
  logic             empty_q;
  logic             empty_next;
  logic             stop_q;
  logic             int_q;
  logic [lsab_pkg::ANCILL_W-1:0] anc_q;

  // marker buffer, one slot always left free
  logic [PTR_W-1:0]              mark_pos [MARK_SLOTS];
  logic [lsab_pkg::ANCILL_W-1:0] mark_anc [MARK_SLOTS];
  logic [MARK_SLOTS_LOG2-1:0]    mark_raddr;
  logic [MARK_SLOTS_LOG2-1:0]    mark_waddr;
  logic [MARK_SLOTS_LOG2-1:0]    mark_waddr_inc;
  logic                          mark_empty;
  logic                          mark_full;
  logic                          mark_push;
  logic                          mark_hit;

  assign do_write = write && (write_queue == QUEUE_ID) && !full;
  assign do_read  = read && (read_queue == QUEUE_ID) && !stop_q;

  always_comb begin
    case ({do_read, do_write})
      2'b10:   len_next = len - 1'b1;
      2'b01:   len_next = len + 1'b1;
      default: len_next = len; // idle or read+write
    endcase
  end

  assign empty_next = (len_next == '0);
  assign full_next  = &len_next; // 63 words

  assign mark_waddr_inc = mark_waddr + 1'b1;
  assign mark_empty     = (mark_raddr == mark_waddr);
  assign mark_full      = (mark_waddr_inc == mark_raddr);
  assign mark_push      = do_write && push.marker && !mark_full;

  // read pointer reaching the oldest pending marker
  assign mark_hit = do_read && !mark_empty && (rptr == mark_pos[mark_raddr]);

  always_ff @(posedge CLK) begin
    if (!RST) begin
      len     <= '0;
      full    <= 1'b0;
      empty_q <= 1'b1;
      stop_q  <= 1'b1;
      int_q   <= 1'b0;
      anc_q   <= '0;
      wptr    <= '0;
      rptr    <= '0;
    end else begin
      len     <= len_next;
      full    <= full_next;
      empty_q <= empty_next;
      stop_q  <= empty_next || mark_hit; // one-cycle stop on marker
      int_q   <= mark_hit && careof_int;
      anc_q   <= mark_anc[mark_raddr];
      if (do_write) begin
        wptr <= wptr + 1'b1;
      end
      if (do_read) begin
        rptr <= rptr + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST) begin
      mark_raddr <= '0;
      mark_waddr <= '0;
      for (int i = 0; i < MARK_SLOTS; i++) begin
        mark_anc[i] <= '0;
      end
    end else begin
      if (mark_hit) begin
        mark_raddr <= mark_raddr + 1'b1;
      end
      if (mark_push) begin
        mark_anc[mark_waddr] <= push.ancill;
        mark_waddr           <= mark_waddr_inc;
      end
    end
  end

  // position of each marked word in the queue region
  always_ff @(posedge CLK) begin
    if (mark_push) begin
      mark_pos[mark_waddr] <= wptr;
    end
  end

  assign status = '{
    empty:   empty_q,
    stop:    stop_q,
    int_out: int_q,
    ancill:  anc_q
  };

endmodule

// File: rtl/lsab_port_mux.sv
`timescale 1ns/1ns

module lsab_port_mux #(
  parameter int PTR_W = 6
) (
  input  logic                                       CLK,
  input  logic                                       RST,
  input  lsab_pkg::lsab_queue_e                      write_queue,
  input  lsab_pkg::lsab_queue_e                      read_queue,
  input  logic [lsab_pkg::NUM_QUEUES-1:0]            do_write,
  input  logic [lsab_pkg::NUM_QUEUES-1:0]            do_read,
  input  logic [lsab_pkg::NUM_QUEUES-1:0][PTR_W-1:0] wptr,
  input  logic [lsab_pkg::NUM_QUEUES-1:0][PTR_W-1:0] rptr,
  input  logic [lsab_pkg::DATA_W-1:0]                wdata,
  output logic                                       ram_we,
  output logic [PTR_W+1:0]                           ram_waddr,
  output logic [lsab_pkg::DATA_W-1:0]                ram_wdata,
  output logic                                       ram_re,
  output logic [PTR_W+1:0]                           ram_raddr,
  input  logic [lsab_pkg::DATA_W-1:0]                ram_rdata,
  output logic [lsab_pkg::DATA_W-1:0]                rd_data
);

  logic re_prev;

  // queue number selects the 64-word region
  always_comb begin
    ram_we    = do_write[write_queue];
    ram_waddr = '0;
    ram_wdata = '0;
    if (ram_we) begin
      ram_waddr = {write_queue, wptr[write_queue]};
      ram_wdata = wdata;
    end
  end

  always_comb begin
    ram_re    = do_read[read_queue];
    ram_raddr = '0;
    if (ram_re) begin
      ram_raddr = {read_queue, rptr[read_queue]};
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST) begin
      re_prev <= 1'b0;
      rd_data <= '0;
    end else begin
      re_prev <= ram_re;
      if (re_prev) begin
        rd_data <= ram_rdata; // held until next accepted read
      end
    end
  end

endmodule

// File: rtl/lsab.sv
`timescale 1ns/1ns

module lsab #(
  parameter int PTR_W = 6
) (
  input  logic                                          CLK,
  input  logic                                          RST,
  input  logic                                          write,
  input  lsab_pkg::lsab_queue_e                         write_queue,
  input  lsab_pkg::lsab_push_t                          push,
  input  logic                                          read,
  input  lsab_pkg::lsab_queue_e                         read_queue,
  input  logic [lsab_pkg::NUM_QUEUES-1:0]               careof_int,
  output logic [lsab_pkg::DATA_W-1:0]                   rd_data,
  output lsab_pkg::lsab_status_t [lsab_pkg::NUM_QUEUES-1:0] status
);

  logic [lsab_pkg::NUM_QUEUES-1:0]            do_write;
  logic [lsab_pkg::NUM_QUEUES-1:0]            do_read;
  logic [lsab_pkg::NUM_QUEUES-1:0][PTR_W-1:0] wptr;
  logic [lsab_pkg::NUM_QUEUES-1:0][PTR_W-1:0] rptr;

  logic                        ram_we;
  logic [PTR_W+1:0]            ram_waddr;
  logic [lsab_pkg::DATA_W-1:0] ram_wdata;
  logic                        ram_re;
  logic [PTR_W+1:0]            ram_raddr;
  logic [lsab_pkg::DATA_W-1:0] ram_rdata;

  for (genvar q = 0; q < lsab_pkg::NUM_QUEUES; q++) begin : g_queue
    lsab_queue_ctrl #(
      .PTR_W          (PTR_W),
      .MARK_SLOTS_LOG2(2),
      .QUEUE_ID       (lsab_pkg::lsab_queue_e'(q))
    ) u_queue_ctrl (
      .CLK        (CLK),
      .RST        (RST),
      .write      (write),
      .write_queue(write_queue),
      .push       (push),
      .read       (read),
      .read_queue (read_queue),
      .careof_int (careof_int[q]),
      .do_write   (do_write[q]),
      .do_read    (do_read[q]),
      .wptr       (wptr[q]),
      .rptr       (rptr[q]),
      .status     (status[q])
    );
  end

  lsab_port_mux #(
    .PTR_W(PTR_W)
  ) u_port_mux (
    .CLK        (CLK),
    .RST        (RST),
    .write_queue(write_queue),
    .read_queue (read_queue),
    .do_write   (do_write),
    .do_read    (do_read),
    .wptr       (wptr),
    .rptr       (rptr),
    .wdata      (push.data),
    .ram_we     (ram_we),
    .ram_waddr  (ram_waddr),
    .ram_wdata  (ram_wdata),
    .ram_re     (ram_re),
    .ram_raddr  (ram_raddr),
    .ram_rdata  (ram_rdata),
    .rd_data    (rd_data)
  );

  // shared storage for all four regions
  lsab_ram #(
    .ADDR_W(PTR_W + 2),
    .DATA_W(lsab_pkg::DATA_W)
  ) u_ram (
    .CLK  (CLK),
    .we   (ram_we),
    .waddr(ram_waddr),
    .wdata(ram_wdata),
    .re   (ram_re),
    .raddr(ram_raddr),
    .rdata(ram_rdata)
  );

endmodule

// File: bench/lsab_tb.sv
`timescale 1ns/1ns

module lsab_tb;

  localparam int SEED        = 98;
  localparam int TIMEOUT     = 300;
  localparam int RAND_CYCLES = 600;
  localparam int MAX_WORDS   = 63;

  logic                         CLK;
  logic                         RST;
  logic                         write;
  lsab_pkg::lsab_queue_e        write_queue;
  lsab_pkg::lsab_push_t         push;
  logic                         read;
  lsab_pkg::lsab_queue_e        read_queue;
  logic [3:0]                   careof_int;
  logic [31:0]                  rd_data;
  lsab_pkg::lsab_status_t [3:0] status;

  // reference model, entries are {recorded marker, ancill, data}
  logic [35:0] fifo_m [4][64];
  int          head_m [4];
  int          cnt_m [4];
  logic [2:0]  pend_code [4][4];
  int          pend_head [4];
  int          pend_cnt [4];
  logic [3:0]  empty_m;
  logic [3:0]  stop_m;
  logic [3:0]  int_m;
  logic [3:0]  anc_ok_m;
  logic [2:0]  anc_m [4];
  logic        rd_pend;
  logic [31:0] rd_pipe;
  logic [31:0] rd_exp;
  logic        acc_w;
  logic        acc_r;
  logic        hit;
  logic        flag;
  logic [35:0] ent;

  int   stop_pulses [4];
  int   int_pulses [4];
  int   val_errors;
  int   timeouts;
  int   seed;
  logic chk_en;

  lsab #(
    .PTR_W(6)
  ) UUT (
    .CLK        (CLK),
    .RST        (RST),
    .write      (write),
    .write_queue(write_queue),
    .push       (push),
    .read       (read),
    .read_queue (read_queue),
    .careof_int (careof_int),
    .rd_data    (rd_data),
    .status     (status)
  );

  always #2 CLK = ~CLK;

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s expected %h got %h", name, exp, act);
      val_errors++;
    end
  endtask

  // model sees the same input values the DUT samples at this edge
  always @(posedge CLK) begin
    if (!RST) begin
      for (int q = 0; q < 4; q++) begin
        head_m[q]    = 0;
        cnt_m[q]     = 0;
        pend_head[q] = 0;
        pend_cnt[q]  = 0;
        anc_m[q]     = '0;
      end
      empty_m  = '1;
      stop_m   = '1;
      int_m    = '0;
      anc_ok_m = '0;
      rd_pend  = 1'b0;
      rd_pipe  = '0;
      rd_exp   = '0;
    end else begin
      if (rd_pend) begin
        rd_exp = rd_pipe; // second edge after the read
      end
      rd_pend = 1'b0;
      for (int q = 0; q < 4; q++) begin
        acc_w = write && (int'(write_queue) == q) && (cnt_m[q] < MAX_WORDS);
        acc_r = read && (int'(read_queue) == q) && !stop_m[q];
        flag  = push.marker && (pend_cnt[q] < 3);
        hit   = 1'b0;
        anc_ok_m[q] = (pend_cnt[q] != 0);
        anc_m[q]    = pend_code[q][pend_head[q]];
        if (acc_r) begin
          ent       = fifo_m[q][head_m[q]];
          head_m[q] = (head_m[q] + 1) % 64;
          cnt_m[q]--;
          rd_pend = 1'b1;
          rd_pipe = ent[31:0];
          if (ent[35]) begin
            hit          = 1'b1;
            pend_head[q] = (pend_head[q] + 1) % 4;
            pend_cnt[q]--;
          end
        end
        if (acc_w) begin
          fifo_m[q][(head_m[q] + cnt_m[q]) % 64] = {flag, push.ancill, push.data};
          cnt_m[q]++;
          if (flag) begin
            pend_code[q][(pend_head[q] + pend_cnt[q]) % 4] = push.ancill;
            pend_cnt[q]++;
          end
        end
        empty_m[q] = (cnt_m[q] == 0);
        stop_m[q]  = empty_m[q] || hit;
        int_m[q]   = hit && careof_int[q];
      end
    end
  end

  always @(negedge CLK) begin
    if (chk_en) begin
      check_val("rd_data", rd_exp, rd_data);
      for (int q = 0; q < 4; q++) begin
        check_val($sformatf("status[%0d].empty", q), empty_m[q], status[q].empty);
        check_val($sformatf("status[%0d].stop", q), stop_m[q], status[q].stop);
        check_val($sformatf("status[%0d].int_out", q), int_m[q], status[q].int_out);
        if (anc_ok_m[q]) begin
          check_val($sformatf("status[%0d].ancill", q), anc_m[q], status[q].ancill);
        end
        if (status[q].stop && !status[q].empty) begin
          stop_pulses[q]++;
        end
        if (status[q].int_out) begin
          int_pulses[q]++;
        end
      end
    end
  end

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge CLK);
      write <= 1'b0;
      read  <= 1'b0;
    end
  endtask

  task automatic write_word(input int q, input logic mk, input logic [2:0] anc,
                            input logic [31:0] d);
    @(posedge CLK);
    write       <= 1'b1;
    write_queue <= lsab_pkg::lsab_queue_e'(q);
    push        <= {mk, anc, d};
    read        <= 1'b0;
  endtask

  task automatic read_one(input int q);
    @(posedge CLK);
    read       <= 1'b1;
    read_queue <= lsab_pkg::lsab_queue_e'(q);
    write      <= 1'b0;
    @(posedge CLK);
    read <= 1'b0;
  endtask

  task automatic wait_ready(input int q);
    int n;
    n = 0;
    @(negedge CLK);
    while (status[q].stop && n < TIMEOUT) begin
      @(negedge CLK);
      n++;
    end
    if (n >= TIMEOUT) begin
      $display("timeout: queue %0d stayed stopped for %0d cycles", q, TIMEOUT);
      timeouts++;
    end
  endtask

  // stream reads until the model queue is empty
  task automatic drain(input int q);
    int n;
    n = 0;
    @(negedge CLK);
    while (cnt_m[q] != 0 && n < TIMEOUT) begin
      @(posedge CLK);
      read       <= 1'b1;
      read_queue <= lsab_pkg::lsab_queue_e'(q);
      write      <= 1'b0;
      @(negedge CLK);
      n++;
    end
    @(posedge CLK);
    read <= 1'b0;
    if (cnt_m[q] != 0) begin
      $display("timeout: queue %0d did not drain within %0d cycles", q, TIMEOUT);
      timeouts++;
    end
  endtask

  task automatic clear_pulses;
    for (int q = 0; q < 4; q++) begin
      stop_pulses[q] = 0;
      int_pulses[q]  = 0;
    end
  endtask

  initial begin
    int r;
    int d;
    CLK         = 1'b0;
    RST         = 1'b0;
    write       = 1'b0;
    write_queue = lsab_pkg::QUEUE_0;
    push        = '0;
    read        = 1'b0;
    read_queue  = lsab_pkg::QUEUE_0;
    careof_int  = '0;
    seed        = SEED;
    val_errors  = 0;
    timeouts    = 0;
    chk_en      = 1'b0;
    clear_pulses();
    repeat (16) @(posedge CLK);
    RST   <= 1'b1;
    chk_en = 1'b1;

    // reset state, then reads into stopped queues
    @(negedge CLK);
    check_val("rd_data", 32'h0, rd_data);
    for (int q = 0; q < 4; q++) begin
      check_val($sformatf("status[%0d].empty", q), 1'b1, status[q].empty);
      check_val($sformatf("status[%0d].stop", q), 1'b1, status[q].stop);
      check_val($sformatf("status[%0d].int_out", q), 1'b0, status[q].int_out);
      check_val($sformatf("status[%0d].ancill", q), 3'd0, status[q].ancill);
    end
    for (int q = 0; q < 4; q++) begin
      read_one(q);
    end
    idle(3);
    @(negedge CLK);
    check_val("rd_data", 32'h0, rd_data);

    // random traffic across all queues
    repeat (RAND_CYCLES) begin
      @(posedge CLK);
      r = $random(seed);
      d = $random(seed);
      write       <= r[0];
      write_queue <= lsab_pkg::lsab_queue_e'(r[4:3]);
      read        <= r[5];
      read_queue  <= lsab_pkg::lsab_queue_e'(r[7:6]);
      careof_int  <= r[11:8];
      push        <= {(r[15:12] == 4'd0), r[18:16], d};
    end
    idle(1);
    for (int q = 0; q < 4; q++) begin
      drain(q);
    end
    idle(3);

    // fill queue 0 past its limit
    for (int i = 0; i < 64; i++) begin
      write_word(0, 1'b0, 3'd0, 32'h0A00_0000 + i);
    end
    idle(3);
    @(negedge CLK);
    check_val("status[0].empty", 1'b0, status[0].empty);
    drain(0);
    idle(3);
    @(negedge CLK);
    check_val("status[0].empty", 1'b1, status[0].empty);

    @(posedge CLK);
    careof_int <= 4'b1010;
    clear_pulses();

    // marker with interrupt on queue 1
    write_word(1, 1'b1, 3'd5, 32'hC0DE_0001);
    write_word(1, 1'b0, 3'd0, 32'hC0DE_0002);
    idle(3);
    @(negedge CLK);
    check_val("status[1].ancill", 3'd5, status[1].ancill);
    drain(1);
    idle(3);
    @(negedge CLK);
    check_val("int_pulses[1]", 1, int_pulses[1]);
    check_val("stop_pulses[1]", 1, stop_pulses[1]);

    // two markers, no interrupt, on queue 2
    write_word(2, 1'b1, 3'd3, 32'hBEEF_0001);
    write_word(2, 1'b0, 3'd0, 32'hBEEF_0002);
    write_word(2, 1'b1, 3'd6, 32'hBEEF_0003);
    write_word(2, 1'b0, 3'd0, 32'hBEEF_0004);
    idle(3);
    wait_ready(2);
    read_one(2);
    idle(3);
    @(negedge CLK);
    check_val("status[2].ancill", 3'd6, status[2].ancill);
    drain(2);
    idle(3);
    @(negedge CLK);
    check_val("int_pulses[2]", 0, int_pulses[2]);
    check_val("stop_pulses[2]", 2, stop_pulses[2]);

    // four markers, only three fit the buffer
    for (int i = 0; i < 4; i++) begin
      write_word(3, 1'b1, 3'(i + 1), 32'hD00D_0000 + i);
    end
    write_word(3, 1'b0, 3'd0, 32'hD00D_00FF);
    idle(3);
    drain(3);
    idle(3);
    @(negedge CLK);
    check_val("stop_pulses[3]", 3, stop_pulses[3]);
    check_val("int_pulses[3]", 3, int_pulses[3]);

    idle(4);
    $display("errors: %0d value mismatches, %0d timeouts", val_errors, timeouts);
    if (val_errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
rtl/lsab_pkg.sv
rtl/lsab_ram.sv
rtl/lsab_queue_ctrl.sv
rtl/lsab_port_mux.sv
rtl/lsab.sv
bench/lsab_tb.sv

// File: Bender.yml
package:
  name: lsab

sources:
  # package first, then leaf modules, then the top level
  - rtl/lsab_pkg.sv
  - rtl/lsab_ram.sv
  - rtl/lsab_queue_ctrl.sv
  - rtl/lsab_port_mux.sv
  - rtl/lsab.sv

  - target: test
    files:
      - bench/lsab_tb.sv

# top modules: lsab (RTL), lsab_tb (testbench)
# file list for simulators: build.f
